//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eurorack
SEED      ?= 66175
BUILD_DIR ?= obj_dir

PASS_MSG  := *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/channel_cal.sv
// Per-channel offset and Q4.12 gain stage with saturation, used on both the ADC and DAC side.
module channel_cal #(
    parameter eurorack_pkg::cal_set_t CAL = eurorack_pkg::CAL_UNITY
) (
    input  logic                 clk_12mhz_i,
    input  logic                 rst_n_i,
    input  eurorack_pkg::frame_t frame_i,
    input  logic                 valid_i,
    output eurorack_pkg::frame_t frame_o,
    output logic                 valid_o
);

    eurorack_pkg::frame_t cal_d;
    eurorack_pkg::frame_t frame_q;
    logic                 valid_q;

    // Removes the offset, scales by the gain and clamps to the sample range.
    // Every intermediate is kept at full width so nothing wraps before the clamp.
    function automatic eurorack_pkg::sample_t apply_cal(
        input eurorack_pkg::sample_t   s,
        input eurorack_pkg::chan_cal_t c
    );
        logic signed [eurorack_pkg::SAMPLE_W:0] diff;
        eurorack_pkg::wide_t                    prod;
        eurorack_pkg::wide_t                    scaled;
        diff   = $signed(s) - $signed(c.offset);
        prod   = diff * $signed(c.gain);
        // Arithmetic shift drops the Q4.12 fraction and keeps the sign.
        scaled = prod >>> eurorack_pkg::GAIN_FRAC;
        return eurorack_pkg::saturate(scaled);
    endfunction

    // Each channel has its own calibration entry.
    always_comb begin
        cal_d.ch0 = apply_cal(frame_i.ch0, CAL.ch0);
        cal_d.ch1 = apply_cal(frame_i.ch1, CAL.ch1);
        cal_d.ch2 = apply_cal(frame_i.ch2, CAL.ch2);
        cal_d.ch3 = apply_cal(frame_i.ch3, CAL.ch3);
    end

    always_ff @(posedge clk_12mhz_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            frame_q <= '0;
            valid_q <= 1'b0;
        end else begin
            // The result holds between frames, so downstream may read it at any time.
            if (valid_i) begin
                frame_q <= cal_d;
            end
            valid_q <= valid_i;
        end
    end

    assign frame_o = frame_q;
    assign valid_o = valid_q;

endmodule

//--- hdl/codec_tdm.sv
// TDM codec transceiver that drives bick and lrck, moves four slots each way and strobes frames.
module codec_tdm (
    input  logic                 clk_12mhz_i,
    input  logic                 rst_n_i,
    input  logic                 sdout1_i,
    input  eurorack_pkg::frame_t dac_frame_i,
    output logic                 bick_o,
    output logic                 lrck_o,
    output logic                 sdin1_o,
    output logic                 pdn_o,
    output eurorack_pkg::frame_t adc_frame_o,
    output logic                 sample_valid_o
);

    // Two system clocks per bit clock, four slots per frame.
    localparam int FRAME_CLKS = 4 * eurorack_pkg::SLOT_BITS * 2;
    localparam int CNT_W      = $clog2(FRAME_CLKS);
    localparam int POS_W      = $clog2(eurorack_pkg::SLOT_BITS);
    localparam int FRAME_BITS = $bits(eurorack_pkg::frame_t);

    logic                  pdn_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [POS_W-1:0]      slot_bit;
    logic                  in_sample;
    logic                  frame_end;
    logic [FRAME_BITS-1:0] rx_sr_q;
    logic [FRAME_BITS-1:0] tx_sr_q;

    // The low counter bit is the bit clock. The rest gives the slot and bit position.
    assign slot_bit  = cnt_q[POS_W:1];

    // Only the top SAMPLE_W bits of a slot carry data. The remainder is padding.
    assign in_sample = slot_bit < POS_W'(eurorack_pkg::SAMPLE_W);

    // The strobe marks the last system cycle of every frame.
    assign frame_end = pdn_q && (cnt_q == CNT_W'(FRAME_CLKS - 1));

    // Bit clock is low in even cycles, so its falling edge lines up with cnt becoming even.
    assign bick_o = cnt_q[0];

    // Frame clock covers the first two slots. It stays low until the codec is released.
    assign lrck_o = pdn_q && (cnt_q < CNT_W'(FRAME_CLKS / 2));

    // Padding bits of each slot are driven as zero.
    assign sdin1_o = tx_sr_q[FRAME_BITS-1] && in_sample;

    assign pdn_o          = pdn_q;
    assign sample_valid_o = frame_end;

    // Slot 0 is shifted in first and ends up in the top bits, which is ch0.
    assign adc_frame_o = eurorack_pkg::frame_t'(rx_sr_q);

    always_ff @(posedge clk_12mhz_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pdn_q   <= 1'b0;
            cnt_q   <= '0;
            rx_sr_q <= '0;
            tx_sr_q <= '0;
        end else begin
            // The codec leaves power-down one cycle after reset and stays up.
            pdn_q <= 1'b1;

            // The frame counter starts together with the power-down release.
            if (frame_end) begin
                cnt_q <= '0;
            end else if (pdn_q) begin
                cnt_q <= cnt_q + 1'b1;
            end

            // ADC data is sampled as bick rises, which is the end of an even cycle.
            if (pdn_q && !cnt_q[0] && in_sample) begin
                rx_sr_q <= {rx_sr_q[FRAME_BITS-2:0], sdout1_i};
            end

            // The next DAC frame is loaded on the strobe and then shifted out
            // one bit each time bick falls inside the sample part of a slot.
            if (frame_end) begin
                tx_sr_q <= dac_frame_i;
            end else if (cnt_q[0] && in_sample) begin
                tx_sr_q <= {tx_sr_q[FRAME_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

//--- hdl/debug_uart.sv
// Debug transmitter that sends a snapshot of one calibrated ADC frame as eight 8N1 bytes.
module debug_uart #(
    parameter int CLKS_PER_BIT = 104
) (
    input  logic                 clk_12mhz_i,
    input  logic                 rst_n_i,
    input  eurorack_pkg::frame_t frame_i,
    input  logic                 valid_i,
    output logic                 uart_tx_o
);

    localparam int FRAME_BITS = $bits(eurorack_pkg::frame_t);
    localparam int CNT_W      = $clog2(CLKS_PER_BIT + 1);

    // Bit positions within one byte on the wire: start, eight data bits, stop.
    localparam logic [3:0] LAST_DATA = 4'd8;
    localparam logic [3:0] STOP_BIT  = 4'd9;

    typedef enum logic {
        ST_IDLE,
        ST_SEND
    } state_t;

    state_t                state_q;
    logic [CNT_W-1:0]      clk_cnt_q;
    logic [3:0]            bit_idx_q;
    logic [2:0]            byte_idx_q;
    logic [FRAME_BITS-1:0] snap_q;
    logic                  tx_q;
    logic                  bit_done;

    assign bit_done  = clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1);
    assign uart_tx_o = tx_q;

    always_ff @(posedge clk_12mhz_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            byte_idx_q <= '0;
            tx_q       <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Frames only get latched while idle. Later ones are dropped.
                    if (valid_i) begin
                        state_q    <= ST_SEND;
                        clk_cnt_q  <= '0;
                        bit_idx_q  <= '0;
                        byte_idx_q <= '0;
                        tx_q       <= 1'b0;
                    end
                end
                default: begin
                    if (!bit_done) begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end else begin
                        clk_cnt_q <= '0;
                        if (bit_idx_q == STOP_BIT) begin
                            bit_idx_q <= '0;
                            // After the last stop bit the line simply stays high.
                            if (byte_idx_q == 3'd7) begin
                                state_q <= ST_IDLE;
                            end else begin
                                byte_idx_q <= byte_idx_q + 1'b1;
                                tx_q       <= 1'b0;
                            end
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            // Data goes out LSB first, then the stop bit.
                            if (bit_idx_q == LAST_DATA) begin
                                tx_q <= 1'b1;
                            end else begin
                                tx_q <= snap_q[FRAME_BITS-8+int'(bit_idx_q)];
                            end
                        end
                    end
                end
            endcase
        end
    end

    // The top byte of the snapshot is the one on the wire. It moves up by a byte
    // once each stop bit ends, so ch0 high goes first.
    always_ff @(posedge clk_12mhz_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            snap_q <= '0;
        end else if (state_q == ST_IDLE && valid_i) begin
            snap_q <= frame_i;
        end else if (state_q == ST_SEND && bit_done && bit_idx_q == STOP_BIT) begin
            snap_q <= {snap_q[FRAME_BITS-9:0], 8'h00};
        end
    end

endmodule

//--- hdl/dsp_mixer.sv
// Fixed four-channel mixer that sits between the ADC and DAC calibration stages.
module dsp_mixer (
    input  logic                 clk_12mhz_i,
    input  logic                 rst_n_i,
    input  eurorack_pkg::frame_t frame_i,
    input  logic                 valid_i,
    output eurorack_pkg::frame_t frame_o,
    output logic                 valid_o
);

    // One guard bit is enough for a negation or a sum of two samples.
    logic signed [eurorack_pkg::SAMPLE_W:0] neg1;
    logic signed [eurorack_pkg::SAMPLE_W:0] sum23;
    logic signed [eurorack_pkg::SAMPLE_W:0] avg01;
    eurorack_pkg::frame_t                   mix_d;
    eurorack_pkg::frame_t                   frame_q;
    logic                                   valid_q;

    always_comb begin
        // Negating full-scale negative needs the guard bit, and the clamp pulls it back.
        neg1  = -$signed(frame_i.ch1);
        sum23 = $signed(frame_i.ch2) + $signed(frame_i.ch3);
        // Average of ch0 and ch1.
        avg01 = ($signed(frame_i.ch0) + $signed(frame_i.ch1)) >>> 1;

        mix_d.ch0 = frame_i.ch0;
        mix_d.ch1 = eurorack_pkg::saturate(neg1);
        mix_d.ch2 = eurorack_pkg::saturate(sum23);
        mix_d.ch3 = eurorack_pkg::saturate(avg01);
    end

    always_ff @(posedge clk_12mhz_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            frame_q <= '0;
            valid_q <= 1'b0;
        end else begin
            if (valid_i) begin
                frame_q <= mix_d;
            end
            valid_q <= valid_i;
        end
    end

    assign frame_o = frame_q;
    assign valid_o = valid_q;

endmodule

//--- hdl/eurorack_pkg.sv
// Shared sample, frame and calibration types for the audio datapath, referenced by scoped name.
package eurorack_pkg;

    // Width of one audio sample as carried through the datapath.
    localparam int SAMPLE_W = 16;

    // Each TDM slot is 32 bit clocks wide. The sample sits in the top bits.
    localparam int SLOT_BITS = 32;

    // Gains are Q4.12, so 4096 represents a gain of exactly 1.0.
    localparam int GAIN_FRAC = 12;

    // Intermediate width that holds a 17-bit difference times a 16-bit gain.
    localparam int WIDE_W = 2 * SAMPLE_W + 1;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [WIDE_W-1:0] wide_t;

    // Channel 0 sits in the most significant bits, matching the slot order on the wire.
    typedef struct packed {
        sample_t ch0;
        sample_t ch1;
        sample_t ch2;
        sample_t ch3;
    } frame_t;

    // Calibration for one channel. The offset is removed first, then the gain is applied.
    typedef struct packed {
        sample_t offset;
        sample_t gain;
    } chan_cal_t;

    typedef struct packed {
        chan_cal_t ch0;
        chan_cal_t ch1;
        chan_cal_t ch2;
        chan_cal_t ch3;
    } cal_set_t;

    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = -16'sh8000;

    // Pass-through calibration with zero offset and unity gain.
    localparam chan_cal_t CAL_ONE = '{offset: '0, gain: sample_t'(2 ** GAIN_FRAC)};
    localparam cal_set_t CAL_UNITY = '{CAL_ONE, CAL_ONE, CAL_ONE, CAL_ONE};

    // Clamps a wide signed intermediate result into the signed sample range.
    function automatic sample_t saturate(input wide_t v);
        if (v > wide_t'(SAMPLE_MAX)) begin
            return SAMPLE_MAX;
        end else if (v < wide_t'(SAMPLE_MIN)) begin
            return SAMPLE_MIN;
        end
        return sample_t'(v);
    endfunction

endpackage

//--- hdl/eurorack_top.sv
// Top level of the audio datapath that connects codec, calibration, mixer and debug UART.
module eurorack_top #(
    parameter eurorack_pkg::cal_set_t ADC_CAL = eurorack_pkg::CAL_UNITY,
    parameter eurorack_pkg::cal_set_t DAC_CAL = eurorack_pkg::CAL_UNITY,
    parameter int UART_CLKS_PER_BIT = 104
) (
    input  logic clk_12mhz_i,
    input  logic rst_n_i,
    input  logic sdout1_i,
    output logic bick_o,
    output logic lrck_o,
    output logic sdin1_o,
    output logic pdn_o,
    output logic uart_tx_o
);

    // Raw codec frame and its strobe.
    eurorack_pkg::frame_t adc_frame;
    logic                 adc_valid;

    // Calibrated inputs, shared by the mixer and the debug UART.
    eurorack_pkg::frame_t cal_in_frame;
    logic                 cal_in_valid;

    // Mixer output, still in calibrated units.
    eurorack_pkg::frame_t mix_frame;
    logic                 mix_valid;

    // DAC codes. The codec picks these up on its next strobe.
    eurorack_pkg::frame_t dac_frame;

    codec_tdm i_codec (
        .clk_12mhz_i   (clk_12mhz_i),
        .rst_n_i       (rst_n_i),
        .sdout1_i      (sdout1_i),
        .dac_frame_i   (dac_frame),
        .bick_o        (bick_o),
        .lrck_o        (lrck_o),
        .sdin1_o       (sdin1_o),
        .pdn_o         (pdn_o),
        .adc_frame_o   (adc_frame),
        .sample_valid_o(adc_valid)
    );

    channel_cal #(
        .CAL(ADC_CAL)
    ) i_adc_cal (
        .clk_12mhz_i(clk_12mhz_i),
        .rst_n_i    (rst_n_i),
        .frame_i    (adc_frame),
        .valid_i    (adc_valid),
        .frame_o    (cal_in_frame),
        .valid_o    (cal_in_valid)
    );

    dsp_mixer i_mixer (
        .clk_12mhz_i(clk_12mhz_i),
        .rst_n_i    (rst_n_i),
        .frame_i    (cal_in_frame),
        .valid_i    (cal_in_valid),
        .frame_o    (mix_frame),
        .valid_o    (mix_valid)
    );

    // The codec samples the DAC frame on its own strobe, so the final valid is not needed.
    channel_cal #(
        .CAL(DAC_CAL)
    ) i_dac_cal (
        .clk_12mhz_i(clk_12mhz_i),
        .rst_n_i    (rst_n_i),
        .frame_i    (mix_frame),
        .valid_i    (mix_valid),
        .frame_o    (dac_frame),
        .valid_o    ()
    );

    debug_uart #(
        .CLKS_PER_BIT(UART_CLKS_PER_BIT)
    ) i_debug_uart (
        .clk_12mhz_i(clk_12mhz_i),
        .rst_n_i    (rst_n_i),
        .frame_i    (cal_in_frame),
        .valid_i    (cal_in_valid),
        .uart_tx_o  (uart_tx_o)
    );

endmodule

//--- sources.f
hdl/eurorack_pkg.sv
hdl/codec_tdm.sv
hdl/channel_cal.sv
hdl/dsp_mixer.sv
hdl/debug_uart.sv
hdl/eurorack_top.sv
test/tb_eurorack.sv

//--- test/tb_eurorack.sv
// Self-checking testbench for eurorack_top with codec and UART models; build it from sources.f.
module tb_eurorack #(
    parameter int SEED = 66175
);

    localparam int CLK_PERIOD     = 20;
    localparam int UART_CPB       = 8;
    localparam int FRAME_CLKS     = 256;
    localparam int TIMEOUT_CYCLES = 60 * FRAME_CLKS + 2000;

    // Large gains on several channels drive the clamps on both sides.
    // The ch1 offset lets full-scale negative input clamp to the most negative code.
    localparam eurorack_pkg::cal_set_t ADC_CAL = '{
        ch0: '{offset: 16'sd200, gain: 16'sd12288},
        ch1: '{offset: 16'sd300, gain: 16'sd4096},
        ch2: '{offset: -16'sd50, gain: 16'sd20480},
        ch3: '{offset: 16'sd0, gain: 16'sd2048}
    };
    localparam eurorack_pkg::cal_set_t DAC_CAL = '{
        ch0: '{offset: 16'sd10, gain: 16'sd4096},
        ch1: '{offset: -16'sd20, gain: 16'sd6144},
        ch2: '{offset: 16'sd0, gain: -16'sd3072},
        ch3: '{offset: -16'sd1000, gain: 16'sd24576}
    };

    logic clk;
    logic rst_n = 1'b0;
    logic sdout1 = 1'b0;
    logic bick;
    logic lrck;
    logic sdin1;
    logic pdn;
    logic uart_tx;

    integer seed = SEED;
    int errors = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int frame_cnt = 0;
    int checked_cnt = 0;
    int pkt_cnt = 0;
    logic rx_reset_seen = 1'b0;

    // Frames queued here go out before any random ones.
    eurorack_pkg::frame_t stim_q[$];
    // Calibrated ADC frames sent since the last UART packet.
    eurorack_pkg::frame_t uart_exp_q[$];

    // Codec model state, kept per frame as seen on the pins.
    eurorack_pkg::frame_t cur_adc = '0;
    eurorack_pkg::frame_t dac_cap = '0;
    eurorack_pkg::frame_t adc_hist[4];
    int bit_pos = 0;
    logic prev_lrck = 1'b0;
    logic prev_bick = 1'b1;
    logic synced = 1'b0;

    eurorack_top #(
        .ADC_CAL          (ADC_CAL),
        .DAC_CAL          (DAC_CAL),
        .UART_CLKS_PER_BIT(UART_CPB)
    ) i_dut (
        .clk_12mhz_i(clk),
        .rst_n_i    (rst_n),
        .sdout1_i   (sdout1),
        .bick_o     (bick),
        .lrck_o     (lrck),
        .sdin1_o    (sdin1),
        .pdn_o      (pdn),
        .uart_tx_o  (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // The run length is bounded by the number of frames the tests need.
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_frame(input string name, input eurorack_pkg::frame_t got,
                               input eurorack_pkg::frame_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // Reference arithmetic is done in 64 bits, well beyond any intermediate range.
    function automatic eurorack_pkg::sample_t clamp_sample(input longint v);
        if (v > 32767) begin
            return 16'sh7fff;
        end else if (v < -32768) begin
            return -16'sh8000;
        end
        return eurorack_pkg::sample_t'(v);
    endfunction

    function automatic eurorack_pkg::sample_t cal_sample(input eurorack_pkg::sample_t s,
                                                         input eurorack_pkg::chan_cal_t c);
        longint diff;
        diff = longint'(s) - longint'(c.offset);
        return clamp_sample((diff * longint'(c.gain)) >>> eurorack_pkg::GAIN_FRAC);
    endfunction

    function automatic eurorack_pkg::frame_t cal_model(input eurorack_pkg::frame_t f,
                                                       input eurorack_pkg::cal_set_t c);
        eurorack_pkg::frame_t r;
        r.ch0 = cal_sample(f.ch0, c.ch0);
        r.ch1 = cal_sample(f.ch1, c.ch1);
        r.ch2 = cal_sample(f.ch2, c.ch2);
        r.ch3 = cal_sample(f.ch3, c.ch3);
        return r;
    endfunction

    function automatic eurorack_pkg::frame_t mix_model(input eurorack_pkg::frame_t f);
        eurorack_pkg::frame_t r;
        r.ch0 = f.ch0;
        r.ch1 = clamp_sample(-longint'(f.ch1));
        r.ch2 = clamp_sample(longint'(f.ch2) + longint'(f.ch3));
        r.ch3 = clamp_sample((longint'(f.ch0) + longint'(f.ch1)) >>> 1);
        return r;
    endfunction

    function automatic eurorack_pkg::frame_t dac_model(input eurorack_pkg::frame_t adc);
        return cal_model(mix_model(cal_model(adc, ADC_CAL)), DAC_CAL);
    endfunction

    // Maps a bit position in the frame to its frame bit, or -1 for slot padding.
    function automatic int frame_bit(input int pos);
        int sb;
        sb = pos % eurorack_pkg::SLOT_BITS;
        if (sb >= eurorack_pkg::SAMPLE_W) begin
            return -1;
        end
        return 63 - ((pos / eurorack_pkg::SLOT_BITS) * eurorack_pkg::SAMPLE_W + sb);
    endfunction

    function automatic eurorack_pkg::frame_t next_adc();
        if (stim_q.size() > 0) begin
            return stim_q.pop_front();
        end
        return {$random(seed), $random(seed)};
    endfunction

    // The DAC frame of frame k carries the ADC frame of frame k-2 through the pipeline.
    task automatic finish_frame();
        eurorack_pkg::frame_t expected;
        if (frame_cnt < 2) begin
            expected = '0;
        end else begin
            expected = dac_model(adc_hist[(frame_cnt - 2) % 4]);
            checked_cnt++;
        end
        check_frame($sformatf("dac_frame[%0d]", frame_cnt), dac_cap, expected);
        adc_hist[frame_cnt % 4] = cur_adc;
        uart_exp_q.push_back(cal_model(cur_adc, ADC_CAL));
        frame_cnt++;
    endtask

    // Codec model. It follows bick and lrck, drives ADC bits while bick is low
    // and captures DAC bits while bick is high.
    always @(negedge clk) begin
        int idx;
        if (!rst_n) begin
            bit_pos       = 0;
            frame_cnt     = 0;
            prev_lrck     = 1'b0;
            prev_bick     = 1'b1;
            synced        = 1'b0;
            rx_reset_seen = 1'b1;
            uart_exp_q.delete();
            sdout1 <= 1'b0;
        end else begin
            check_bit("bick_o", bick, ~prev_bick);
            prev_bick = bick;
            if (!bick) begin
                // Bick has just fallen, so a new bit period starts.
                if (lrck && !prev_lrck) begin
                    if (synced && bit_pos != 127) begin
                        report_problem($sformatf("Frame clock restarted after %0d bit clocks",
                                                 bit_pos + 1));
                    end
                    synced  = 1'b1;
                    bit_pos = 0;
                    dac_cap = '0;
                    cur_adc = next_adc();
                end else if (bit_pos == 127) begin
                    report_problem("Frame clock did not start a new frame after 128 bit clocks");
                    bit_pos = 0;
                end else begin
                    bit_pos++;
                end
                prev_lrck = lrck;
                idx = frame_bit(bit_pos);
                sdout1 <= (idx >= 0) ? cur_adc[idx] : 1'b0;
            end else if (synced) begin
                check_bit("lrck_o", lrck, bit_pos < 64);
                idx = frame_bit(bit_pos);
                if (idx >= 0) begin
                    dac_cap[idx] = sdin1;
                end else begin
                    check_bit("sdin1_o", sdin1, 1'b0);
                end
                if (bit_pos == 127) begin
                    finish_frame();
                end
            end
        end
    end

    // Samples one 8N1 byte near the middle of each bit, starting at the start bit's edge.
    task automatic receive_byte(output logic [7:0] data, output logic start_bad,
                                output logic stop_bad);
        repeat (UART_CPB / 2 - 1) @(negedge clk);
        start_bad = uart_tx;
        for (int i = 0; i < 8; i++) begin
            repeat (UART_CPB) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (UART_CPB) @(negedge clk);
        stop_bad = !uart_tx;
    endtask

    task automatic check_packet(input eurorack_pkg::frame_t pkt);
        logic found;
        found = 1'b0;
        foreach (uart_exp_q[i]) begin
            if (uart_exp_q[i] == pkt) begin
                found = 1'b1;
            end
        end
        if (uart_exp_q.size() == 0) begin
            report_problem("UART packet arrived with no ADC frame sent since the previous one");
        end else if (!found) begin
            check_frame("uart_packet", pkt, uart_exp_q[uart_exp_q.size() - 1]);
        end
        uart_exp_q.delete();
        pkt_cnt++;
    endtask

    // UART receiver. Bytes cut short by a reset are dropped together with the packet.
    initial begin : uart_receiver
        logic [7:0]  data;
        logic [63:0] pkt;
        logic        start_bad;
        logic        stop_bad;
        int          byte_idx;
        byte_idx = 0;
        pkt      = '0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                byte_idx = 0;
            end else if (uart_tx === 1'b0) begin
                rx_reset_seen = 1'b0;
                receive_byte(data, start_bad, stop_bad);
                if (rx_reset_seen) begin
                    byte_idx = 0;
                end else begin
                    if (start_bad) begin
                        report_problem("UART start bit went high before the middle of the bit");
                    end
                    if (stop_bad) begin
                        report_problem($sformatf("UART framing error: stop bit of byte %0d is low",
                                                 byte_idx));
                    end
                    pkt = {pkt[55:0], data};
                    byte_idx++;
                    if (byte_idx == 8) begin
                        check_packet(pkt);
                        byte_idx = 0;
                    end
                end
            end
        end
    end

    task automatic check_reset_pins();
        check_bit("uart_tx_o", uart_tx, 1'b1);
        check_bit("lrck_o", lrck, 1'b0);
        check_bit("bick_o", bick, 1'b0);
        check_bit("sdin1_o", sdin1, 1'b0);
        check_bit("pdn_o", pdn, 1'b0);
    endtask

    // Holds reset for four cycles, then checks the pins before and after the first edge.
    task automatic pulse_reset();
        @(negedge clk);
        rst_n <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_reset_pins();
        end
        rst_n <= 1'b1;
        #1;
        check_reset_pins();
        @(negedge clk);
        check_bit("pdn_o", pdn, 1'b1);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin : run_tests
        int target;
        pulse_reset();
        wait (frame_cnt >= 2);
        finish_test("reset state");

        // Frame format is checked on every bit by the codec model.
        wait (frame_cnt >= 4);
        finish_test("frame format");

        target = checked_cnt + 30;
        wait (checked_cnt >= target);
        finish_test("datapath");

        // Full scale both ways, plus the most negative ch1 that overflows on negation.
        stim_q.push_back({16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff});
        stim_q.push_back({16'h8000, 16'h8000, 16'h8000, 16'h8000});
        stim_q.push_back({16'h7fff, 16'h8000, 16'h7fff, 16'h8000});
        stim_q.push_back({16'h8000, 16'h8000, 16'h8000, 16'h7fff});
        target = checked_cnt + 7;
        wait (checked_cnt >= target);
        finish_test("saturation");

        wait (pkt_cnt >= 4);
        finish_test("debug uart");

        pulse_reset();
        wait (frame_cnt >= 2);
        target = checked_cnt + 10;
        wait (checked_cnt >= target);
        finish_test("reset in mid-run");

        $display("Tests run %0d, tests failed %0d, errors %0d, frames checked %0d, packets %0d",
                 tests_run, tests_failed, errors, checked_cnt, pkt_cnt);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
